// ==== common/ex_pkg.sv ====
// shared widths, alu and branch operation enums, forwarding record widths
`default_nettype none

package ex_pkg;

  // register width and register address width, fixed by rv64
  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;

  // alu operations, four bits
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

  // branch and jump operations, four bits
  typedef enum logic [3:0] {
    bj_none = 4'd0,
    bj_beq  = 4'd1,
    bj_bne  = 4'd2,
    bj_blt  = 4'd3,
    bj_bge  = 4'd4,
    bj_bltu = 4'd5,
    bj_bgeu = 4'd6,
    bj_jal  = 4'd7,
    bj_jalr = 4'd8
  } bj_op_e;

  // memory stage forwarding record
  // msb to lsb: wr_ena, addr, data, is_load
  localparam int mem_fwd_w = 1 + reg_addr_w + xlen + 1;

  // write-back forwarding record
  // msb to lsb: wr_ena, addr, data
  localparam int wb_fwd_w = 1 + reg_addr_w + xlen;

endpackage

`default_nettype wire

// ==== ex_stage/ex_ctrl.sv ====
// execute stage register, valid/allowin control, redirect handshake, operand select
`default_nettype none

module ex_ctrl import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic [xlen-1:0]       in_pc,
  input  logic [reg_addr_w-1:0] in_rs1_addr,
  input  logic [reg_addr_w-1:0] in_rs2_addr,
  input  logic                  in_use_rs1,
  input  logic                  in_use_rs2,
  input  logic [xlen-1:0]       in_op1,
  input  logic [xlen-1:0]       in_op2,
  input  alu_op_e               in_alu_op,
  input  logic                  in_is_word,
  input  bj_op_e                in_bj_op,
  input  logic [xlen-1:0]       in_imm,
  input  logic                  in_rd_wr_ena,
  input  logic [reg_addr_w-1:0] in_rd_addr,
  output logic                  ex_allowin,
  input  logic                  mem_allowin,
  input  logic                  hazard,
  input  logic [xlen-1:0]       rs1_fwd,
  input  logic [xlen-1:0]       rs2_fwd,
  input  logic [xlen-1:0]       alu_result,
  input  logic                  bj_taken_calc,
  output logic                  out_valid,
  output logic [xlen-1:0]       out_pc,
  output logic [xlen-1:0]       out_result,
  output logic                  out_rd_wr_ena,
  output logic [reg_addr_w-1:0] out_rd_addr,
  output logic [xlen-1:0]       out_store_data,
  output logic                  bj_valid,
  output logic                  bj_taken,
  input  logic                  bj_ready,
  output logic [reg_addr_w-1:0] ex_rs1_addr,
  output logic [reg_addr_w-1:0] ex_rs2_addr,
  output logic                  ex_use_rs1,
  output logic                  ex_use_rs2,
  output logic [xlen-1:0]       alu_op1,
  output logic [xlen-1:0]       alu_op2,
  output alu_op_e               alu_op,
  output logic                  is_word,
  output bj_op_e                bj_op,
  output logic [xlen-1:0]       ex_pc,
  output logic [xlen-1:0]       ex_imm
);

  logic                  ex_valid;
  logic                  bj_done;
  logic                  ready_go;
  logic                  bj_fire;
  logic                  is_bj;
  logic [xlen-1:0]       op1_r;
  logic [xlen-1:0]       op2_r;
  logic                  use_rs1_r;
  logic                  use_rs2_r;
  logic                  rd_wr_ena_r;
  logic [reg_addr_w-1:0] rd_addr_r;

  // redirect goes out once per branch, only after the hazard clears
  assign is_bj    = (bj_op != bj_none);
  assign bj_valid = ex_valid && is_bj && !hazard && !bj_done;
  assign bj_fire  = bj_valid && bj_ready;

  assign ready_go   = !hazard && (!is_bj || bj_done || bj_fire);
  assign ex_allowin = !ex_valid || (ready_go && mem_allowin);
  assign out_valid  = ex_valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
      bj_done  <= 1'b0;
    end else begin
      if (ex_allowin) begin
        ex_valid <= in_valid;
      end
      // remember a finished redirect while the item is held by back-pressure
      if (ex_allowin) begin
        bj_done <= 1'b0;
      end else if (bj_fire) begin
        bj_done <= 1'b1;
      end
    end
  end

  // payload, loaded on accept
  always_ff @(posedge clk) begin
    if (in_valid && ex_allowin) begin
      ex_pc       <= in_pc;
      ex_rs1_addr <= in_rs1_addr;
      ex_rs2_addr <= in_rs2_addr;
      use_rs1_r   <= in_use_rs1;
      use_rs2_r   <= in_use_rs2;
      op1_r       <= in_op1;
      op2_r       <= in_op2;
      alu_op      <= in_alu_op;
      is_word     <= in_is_word;
      bj_op       <= in_bj_op;
      ex_imm      <= in_imm;
      rd_wr_ena_r <= in_rd_wr_ena;
      rd_addr_r   <= in_rd_addr;
    end
  end

  // an empty stage reads no registers, so no false hazard
  assign ex_use_rs1 = use_rs1_r && ex_valid;
  assign ex_use_rs2 = use_rs2_r && ex_valid;

  // operand select
  assign alu_op1 = use_rs1_r ? rs1_fwd : op1_r;
  assign alu_op2 = use_rs2_r ? rs2_fwd : op2_r;

  assign out_pc         = ex_pc;
  assign out_result     = alu_result;
  assign out_store_data = rs2_fwd;
  assign out_rd_wr_ena  = rd_wr_ena_r;
  assign out_rd_addr    = rd_addr_r;
  assign bj_taken       = bj_taken_calc;

endmodule

`default_nettype wire

// ==== ex_stage/ex_forward.sv ====
// operand bypass from memory and write-back stages, load-use hazard detection
`default_nettype none

module ex_forward import ex_pkg::*; (
  input  logic [reg_addr_w-1:0] ex_rs1_addr,
  input  logic [reg_addr_w-1:0] ex_rs2_addr,
  input  logic                  ex_use_rs1,
  input  logic                  ex_use_rs2,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  input  logic                  mem_fwd_wr_ena,
  input  logic [reg_addr_w-1:0] mem_fwd_addr,
  input  logic [xlen-1:0]       mem_fwd_data,
  input  logic                  mem_fwd_is_load,
  input  logic                  wb_fwd_wr_ena,
  input  logic [reg_addr_w-1:0] wb_fwd_addr,
  input  logic [xlen-1:0]       wb_fwd_data,
  output logic [xlen-1:0]       rs1_fwd,
  output logic [xlen-1:0]       rs2_fwd,
  output logic                  hazard
);

  logic [mem_fwd_w-1:0] mem_rec;
  logic [wb_fwd_w-1:0]  wb_rec;

  assign mem_rec = {mem_fwd_wr_ena, mem_fwd_addr, mem_fwd_data, mem_fwd_is_load};
  assign wb_rec  = {wb_fwd_wr_ena, wb_fwd_addr, wb_fwd_data};

  // true when the memory stage writes this nonzero source
  function automatic logic mem_hit(input logic [reg_addr_w-1:0] addr,
                                   input logic [mem_fwd_w-1:0]  rec);
    return rec[mem_fwd_w-1] && (rec[mem_fwd_w-2 -: reg_addr_w] == addr) && (addr != '0);
  endfunction

  // newest value wins: memory, then write-back, then register file
  function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] addr,
                                           input logic [xlen-1:0]       rf_data,
                                           input logic [mem_fwd_w-1:0]  mrec,
                                           input logic [wb_fwd_w-1:0]   wrec);
    logic wb_hit;
    wb_hit = wrec[wb_fwd_w-1] && (wrec[wb_fwd_w-2 -: reg_addr_w] == addr) && (addr != '0);
    if (mem_hit(addr, mrec)) begin
      return mrec[xlen:1];
    end else if (wb_hit) begin
      return wrec[xlen-1:0];
    end
    return rf_data;
  endfunction

  assign rs1_fwd = pick(ex_rs1_addr, rs1_data, mem_rec, wb_rec);
  assign rs2_fwd = pick(ex_rs2_addr, rs2_data, mem_rec, wb_rec);

  // load data is not there yet, so wait for it
  assign hazard = mem_rec[0] &&
                  ((ex_use_rs1 && mem_hit(ex_rs1_addr, mem_rec)) ||
                   (ex_use_rs2 && mem_hit(ex_rs2_addr, mem_rec)));

endmodule

`default_nettype wire

// ==== ex_stage/ex_alu.sv ====
// integer alu with rv64 word-operation truncation and sign extension
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  logic [xlen-1:0] alu_op1,
  input  logic [xlen-1:0] alu_op2,
  input  alu_op_e         alu_op,
  input  logic            is_word,
  output logic [xlen-1:0] alu_result
);

  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [xlen-1:0] a_zext;
  logic [5:0]      shamt;
  logic [xlen-1:0] raw;

  // word mode works on the sign-extended low halves
  always_comb begin
    if (is_word) begin
      a = {{32{alu_op1[31]}}, alu_op1[31:0]};
      b = {{32{alu_op2[31]}}, alu_op2[31:0]};
    end else begin
      a = alu_op1;
      b = alu_op2;
    end
  end

  // logical right shift needs zeros above bit 31 in word mode
  assign a_zext = is_word ? {32'b0, alu_op1[31:0]} : alu_op1;

  // 5-bit shift amount for word ops, 6-bit otherwise
  assign shamt = is_word ? {1'b0, alu_op2[4:0]} : alu_op2[5:0];

  always_comb begin
    case (alu_op)
      alu_add: begin
        raw = a + b;
      end
      alu_sub: begin
        raw = a - b;
      end
      alu_sll: begin
        raw = a << shamt;
      end
      alu_slt: begin
        raw = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      end
      alu_sltu: begin
        // sign extension keeps the unsigned order of 32-bit values
        raw = {{(xlen-1){1'b0}}, a < b};
      end
      alu_xor: begin
        raw = a ^ b;
      end
      alu_srl: begin
        raw = a_zext >> shamt;
      end
      alu_sra: begin
        raw = $signed(a) >>> shamt;
      end
      alu_or: begin
        raw = a | b;
      end
      alu_and: begin
        raw = a & b;
      end
      default: begin
        raw = '0;
      end
    endcase
  end

  // word results are sign-extended from bit 31
  assign alu_result = is_word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

// ==== ex_stage/ex_branch.sv ====
// branch comparison, taken decision and jump target computation
`default_nettype none

module ex_branch import ex_pkg::*; (
  input  bj_op_e          bj_op,
  input  logic [xlen-1:0] rs1_fwd,
  input  logic [xlen-1:0] rs2_fwd,
  input  logic [xlen-1:0] ex_pc,
  input  logic [xlen-1:0] ex_imm,
  output logic            bj_taken_calc,
  output logic [xlen-1:0] bj_target
);

  logic            eq;
  logic            lt;
  logic            ltu;
  logic [xlen-1:0] jalr_sum;

  assign eq  = (rs1_fwd == rs2_fwd);
  assign lt  = ($signed(rs1_fwd) < $signed(rs2_fwd));
  assign ltu = (rs1_fwd < rs2_fwd);

  always_comb begin
    case (bj_op)
      bj_beq:  bj_taken_calc = eq;
      bj_bne:  bj_taken_calc = !eq;
      bj_blt:  bj_taken_calc = lt;
      bj_bge:  bj_taken_calc = !lt;
      bj_bltu: bj_taken_calc = ltu;
      bj_bgeu: bj_taken_calc = !ltu;
      // jumps always redirect
      bj_jal:  bj_taken_calc = 1'b1;
      bj_jalr: bj_taken_calc = 1'b1;
      default: bj_taken_calc = 1'b0;
    endcase
  end

  // jalr clears bit 0 of rs1 + imm
  assign jalr_sum = rs1_fwd + ex_imm;

  assign bj_target = (bj_op == bj_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : ex_pc + ex_imm;

endmodule

`default_nettype wire

// ==== hdl/ex_top.sv ====
// execute stage top, control plus forward, alu and branch datapath
`default_nettype none

module ex_top import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic [xlen-1:0]       in_pc,
  input  logic [reg_addr_w-1:0] in_rs1_addr,
  input  logic [reg_addr_w-1:0] in_rs2_addr,
  input  logic                  in_use_rs1,
  input  logic                  in_use_rs2,
  input  logic [xlen-1:0]       in_op1,
  input  logic [xlen-1:0]       in_op2,
  input  alu_op_e               in_alu_op,
  input  logic                  in_is_word,
  input  bj_op_e                in_bj_op,
  input  logic [xlen-1:0]       in_imm,
  input  logic                  in_rd_wr_ena,
  input  logic [reg_addr_w-1:0] in_rd_addr,
  output logic                  ex_allowin,
  output logic                  out_valid,
  output logic [xlen-1:0]       out_pc,
  output logic [xlen-1:0]       out_result,
  output logic [xlen-1:0]       out_store_data,
  output logic                  out_rd_wr_ena,
  output logic [reg_addr_w-1:0] out_rd_addr,
  input  logic                  mem_allowin,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  input  logic                  mem_fwd_wr_ena,
  input  logic [reg_addr_w-1:0] mem_fwd_addr,
  input  logic [xlen-1:0]       mem_fwd_data,
  input  logic                  mem_fwd_is_load,
  input  logic                  wb_fwd_wr_ena,
  input  logic [reg_addr_w-1:0] wb_fwd_addr,
  input  logic [xlen-1:0]       wb_fwd_data,
  output logic                  bj_valid,
  output logic                  bj_taken,
  output logic [xlen-1:0]       bj_target,
  input  logic                  bj_ready
);

  logic            ex_use_rs1;
  logic            ex_use_rs2;
  logic [xlen-1:0] rs1_fwd;
  logic [xlen-1:0] rs2_fwd;
  logic            hazard;
  logic [xlen-1:0] alu_op1;
  logic [xlen-1:0] alu_op2;
  alu_op_e         alu_op;
  logic            is_word;
  bj_op_e          bj_op;
  logic [xlen-1:0] ex_pc;
  logic [xlen-1:0] ex_imm;
  logic [xlen-1:0] alu_result;
  logic            bj_taken_calc;

  ex_ctrl i_ctrl (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_pc          (in_pc),
    .in_rs1_addr    (in_rs1_addr),
    .in_rs2_addr    (in_rs2_addr),
    .in_use_rs1     (in_use_rs1),
    .in_use_rs2     (in_use_rs2),
    .in_op1         (in_op1),
    .in_op2         (in_op2),
    .in_alu_op      (in_alu_op),
    .in_is_word     (in_is_word),
    .in_bj_op       (in_bj_op),
    .in_imm         (in_imm),
    .in_rd_wr_ena   (in_rd_wr_ena),
    .in_rd_addr     (in_rd_addr),
    .ex_allowin     (ex_allowin),
    .mem_allowin    (mem_allowin),
    .hazard         (hazard),
    .rs1_fwd        (rs1_fwd),
    .rs2_fwd        (rs2_fwd),
    .alu_result     (alu_result),
    .bj_taken_calc  (bj_taken_calc),
    .out_valid      (out_valid),
    .out_pc         (out_pc),
    .out_result     (out_result),
    .out_rd_wr_ena  (out_rd_wr_ena),
    .out_rd_addr    (out_rd_addr),
    .out_store_data (out_store_data),
    .bj_valid       (bj_valid),
    .bj_taken       (bj_taken),
    .bj_ready       (bj_ready),
    .ex_rs1_addr    (rs1_addr),
    .ex_rs2_addr    (rs2_addr),
    .ex_use_rs1     (ex_use_rs1),
    .ex_use_rs2     (ex_use_rs2),
    .alu_op1        (alu_op1),
    .alu_op2        (alu_op2),
    .alu_op         (alu_op),
    .is_word        (is_word),
    .bj_op          (bj_op),
    .ex_pc          (ex_pc),
    .ex_imm         (ex_imm)
  );

  // register file answers for the addresses held in the stage register
  ex_forward i_forward (
    .ex_rs1_addr     (rs1_addr),
    .ex_rs2_addr     (rs2_addr),
    .ex_use_rs1      (ex_use_rs1),
    .ex_use_rs2      (ex_use_rs2),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .mem_fwd_wr_ena  (mem_fwd_wr_ena),
    .mem_fwd_addr    (mem_fwd_addr),
    .mem_fwd_data    (mem_fwd_data),
    .mem_fwd_is_load (mem_fwd_is_load),
    .wb_fwd_wr_ena   (wb_fwd_wr_ena),
    .wb_fwd_addr     (wb_fwd_addr),
    .wb_fwd_data     (wb_fwd_data),
    .rs1_fwd         (rs1_fwd),
    .rs2_fwd         (rs2_fwd),
    .hazard          (hazard)
  );

  ex_alu i_alu (
    .alu_op1    (alu_op1),
    .alu_op2    (alu_op2),
    .alu_op     (alu_op),
    .is_word    (is_word),
    .alu_result (alu_result)
  );

  ex_branch i_branch (
    .bj_op         (bj_op),
    .rs1_fwd       (rs1_fwd),
    .rs2_fwd       (rs2_fwd),
    .ex_pc         (ex_pc),
    .ex_imm        (ex_imm),
    .bj_taken_calc (bj_taken_calc),
    .bj_target     (bj_target)
  );

endmodule

`default_nettype wire

// ==== tb/ex_top_sva.sv ====
// bound assertions on the output and redirect handshakes and the reset state
`default_nettype none

module ex_top_sva import ex_pkg::*; (
  input logic                  clk,
  input logic                  rst,
  input logic                  out_valid,
  input logic                  mem_allowin,
  input logic [xlen-1:0]       out_pc,
  input logic [xlen-1:0]       out_result,
  input logic [reg_addr_w-1:0] out_rd_addr,
  input logic                  bj_valid,
  input logic                  bj_ready,
  input logic                  bj_taken,
  input logic [xlen-1:0]       bj_target
);

  // held item keeps its payload until memory takes it
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !mem_allowin |=> out_valid && $stable(out_pc) &&
                                  $stable(out_result) && $stable(out_rd_addr))
    else $error("out_valid payload changed under back-pressure");

  a_bj_stable: assert property (@(posedge clk) disable iff (rst)
    bj_valid && !bj_ready |=> bj_valid && $stable(bj_taken) && $stable(bj_target))
    else $error("redirect changed before bj_ready");

  a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !out_valid && !bj_valid)
    else $error("stage not idle right after reset");

endmodule

bind ex_top ex_top_sva i_sva (
  .clk         (clk),
  .rst         (rst),
  .out_valid   (out_valid),
  .mem_allowin (mem_allowin),
  .out_pc      (out_pc),
  .out_result  (out_result),
  .out_rd_addr (out_rd_addr),
  .bj_valid    (bj_valid),
  .bj_ready    (bj_ready),
  .bj_taken    (bj_taken),
  .bj_target   (bj_target)
);

`default_nettype wire

// ==== tb/ex_top_tb.sv ====
// ex_top testbench with clock, reset, register file model, file-driven ops, checks and report
`default_nettype none

module ex_top_tb;
  import ex_pkg::*;

  localparam int n_ops    = 30;
  localparam int n_fields = 26;
  localparam int n_words  = n_ops * n_fields;
  localparam int max_wait = 64;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  in_valid;
  logic [xlen-1:0]       in_pc;
  logic [reg_addr_w-1:0] in_rs1_addr;
  logic [reg_addr_w-1:0] in_rs2_addr;
  logic                  in_use_rs1;
  logic                  in_use_rs2;
  logic [xlen-1:0]       in_op1;
  logic [xlen-1:0]       in_op2;
  alu_op_e               in_alu_op;
  logic                  in_is_word;
  bj_op_e                in_bj_op;
  logic [xlen-1:0]       in_imm;
  logic                  in_rd_wr_ena;
  logic [reg_addr_w-1:0] in_rd_addr;
  logic                  ex_allowin;
  logic                  out_valid;
  logic [xlen-1:0]       out_pc;
  logic [xlen-1:0]       out_result;
  logic [xlen-1:0]       out_store_data;
  logic                  out_rd_wr_ena;
  logic [reg_addr_w-1:0] out_rd_addr;
  logic                  mem_allowin;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic                  mem_fwd_wr_ena;
  logic [reg_addr_w-1:0] mem_fwd_addr;
  logic [xlen-1:0]       mem_fwd_data;
  logic                  mem_fwd_is_load;
  logic                  wb_fwd_wr_ena;
  logic [reg_addr_w-1:0] wb_fwd_addr;
  logic [xlen-1:0]       wb_fwd_data;
  logic                  bj_valid;
  logic                  bj_taken;
  logic [xlen-1:0]       bj_target;
  logic                  bj_ready;

  logic [63:0]     vec [0:n_words-1];
  logic [xlen-1:0] rf  [0:31];
  int              seed;
  int              mismatch_count;
  int              protocol_count;

  ex_top i_dut (.*);

  always #20 clk = ~clk;

  // register file model, x0 reads zero
  assign rs1_data = (rs1_addr == 5'd0) ? 64'd0 : rf[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 64'd0 : rf[rs2_addr];

  // newest value of a source register, memory stage before write-back before register file
  function automatic logic [xlen-1:0] source_value(input logic [reg_addr_w-1:0] addr,
                                                   input logic                  mem_ena,
                                                   input logic [reg_addr_w-1:0] mem_addr,
                                                   input logic [xlen-1:0]       mem_data,
                                                   input logic                  wb_ena,
                                                   input logic [reg_addr_w-1:0] wb_addr,
                                                   input logic [xlen-1:0]       wb_data);
    if (addr == 5'd0) begin
      return 64'd0;
    end else if (mem_ena && mem_addr == addr) begin
      return mem_data;
    end else if (wb_ena && wb_addr == addr) begin
      return wb_data;
    end
    return rf[addr];
  endfunction

  task automatic check_result(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                              input int op, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch at %0t: op %0d %s %h, expected %h", $time, op, what, got, exp);
    end
  endtask

  task automatic check_branch(input logic got_taken, input logic [xlen-1:0] got_target,
                              input logic exp_taken, input logic [xlen-1:0] exp_target,
                              input int op);
    if (got_taken !== exp_taken || got_target !== exp_target) begin
      mismatch_count++;
      $display("Mismatch at %0t: op %0d taken %b target %h, expected %b %h",
               $time, op, got_taken, got_target, exp_taken, exp_target);
    end
  endtask

  task automatic check_rd(input logic got_ena, input logic [reg_addr_w-1:0] got,
                          input logic exp_ena, input logic [reg_addr_w-1:0] exp,
                          input int op);
    if (got_ena !== exp_ena || got !== exp) begin
      mismatch_count++;
      $display("Mismatch at %0t: op %0d rd write %b to %0d, expected %b to %0d",
               $time, op, got_ena, got, exp_ena, exp);
    end
  endtask

  task automatic protocol_error(input string msg);
    protocol_count++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic report_and_finish(input bit timed_out);
    $display("error count: %0d mismatches, %0d protocol errors", mismatch_count,
             protocol_count);
    if (!timed_out && mismatch_count == 0 && protocol_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  task automatic check_idle(input string when);
    if (out_valid !== 1'b0 || bj_valid !== 1'b0 || ex_allowin !== 1'b1) begin
      protocol_error({"stage not idle ", when});
    end
  endtask

  task automatic run_op(input int op, input logic [9:0] b);
    logic [63:0]     f [0:25];
    logic [4:0]      k;
    logic [4:0]      sel;
    logic [xlen-1:0] exp_result;
    logic [xlen-1:0] exp_store;
    logic            rd_wr;
    bj_op_e          bop;
    int              lstall;
    int              mstall;
    int              bstall;
    int              cyc;
    int              held;
    int              bwait;
    int              waits;
    bit              done;
    bit              fired;
    bit              saw_out;
    bit              saw_bj_wait;
    for (k = 5'd0; k < 5'd26; k = k + 5'd1) begin
      f[k] = vec[b + {5'd0, k}];
    end
    bop    = bj_op_e'(f[9][3:0]);
    lstall = f[19][31:0];
    mstall = f[20][31:0];
    bstall = f[21][31:0];
    sel    = f[22][4:0];
    // selector picks a model register added to the literal part
    exp_result = f[23] + ((sel != 5'd0) ? rf[sel] : 64'd0);
    exp_store  = source_value(f[2][4:0], f[12][0], f[13][4:0], f[14],
                              f[16][0], f[17][4:0], f[18]);
    // conditional branches write no register
    rd_wr = !(bop inside {bj_beq, bj_bne, bj_blt, bj_bge, bj_bltu, bj_bgeu});

    @(posedge clk);
    in_valid        <= 1'b1;
    in_pc           <= f[0];
    in_rs1_addr     <= f[1][4:0];
    in_rs2_addr     <= f[2][4:0];
    in_use_rs1      <= f[3][0];
    in_use_rs2      <= f[4][0];
    in_op1          <= f[5];
    in_op2          <= f[6];
    in_alu_op       <= alu_op_e'(f[7][3:0]);
    in_is_word      <= f[8][0];
    in_bj_op        <= bop;
    in_imm          <= f[10];
    in_rd_wr_ena    <= rd_wr;
    in_rd_addr      <= f[11][4:0];
    mem_fwd_wr_ena  <= f[12][0];
    mem_fwd_addr    <= f[13][4:0];
    mem_fwd_data    <= f[14];
    mem_fwd_is_load <= f[15][0];
    wb_fwd_wr_ena   <= f[16][0];
    wb_fwd_addr     <= f[17][4:0];
    wb_fwd_data     <= f[18];
    mem_allowin     <= (mstall == 0);
    bj_ready        <= (bstall == 0);

    waits = 0;
    @(negedge clk);
    while (!ex_allowin) begin
      waits++;
      if (waits > max_wait) begin
        protocol_error("timeout waiting for ex_allowin");
        report_and_finish(1'b1);
      end
      @(negedge clk);
    end
    @(posedge clk);
    in_valid <= 1'b0;

    cyc   = 0;
    held  = 0;
    bwait = 0;
    done  = 1'b0;
    fired = 1'b0;
    while (!done) begin
      @(negedge clk);
      saw_out     = out_valid;
      saw_bj_wait = bj_valid && !bj_ready;
      if (cyc < lstall && (out_valid || bj_valid)) begin
        protocol_error("stage output raised during load-use stall");
      end
      if (bop == bj_none && bj_valid) begin
        protocol_error("redirect raised for a non-branch operation");
      end
      if (bj_valid && bj_ready) begin
        fired = 1'b1;
        check_branch(bj_taken, bj_target, f[24][0], f[25], op);
      end
      if (bop != bj_none && out_valid && !fired) begin
        protocol_error("out_valid raised before the redirect handshake");
      end
      if (out_valid && mem_allowin) begin
        check_result(out_result, exp_result, op, "result");
        check_result(out_pc, f[0], op, "pc");
        check_result(out_store_data, exp_store, op, "store data");
        check_rd(out_rd_wr_ena, out_rd_addr, rd_wr, f[11][4:0], op);
        done = 1'b1;
      end else if (ex_allowin) begin
        protocol_error("ex_allowin high while the stage holds an item");
      end
      @(posedge clk);
      if (!done) begin
        cyc++;
        if (cyc == lstall) begin
          mem_fwd_is_load <= 1'b0;
        end
        if (saw_out) begin
          held++;
          if (held >= mstall) begin
            mem_allowin <= 1'b1;
          end
        end
        if (saw_bj_wait) begin
          bwait++;
          if (bwait >= bstall) begin
            bj_ready <= 1'b1;
          end
        end
        if (cyc > max_wait) begin
          protocol_error("timeout waiting for out_valid");
          report_and_finish(1'b1);
        end
      end
    end

    // transfer edge, return the neighbours to idle
    mem_fwd_wr_ena  <= 1'b0;
    mem_fwd_is_load <= 1'b0;
    wb_fwd_wr_ena   <= 1'b0;
    bj_ready        <= 1'b0;
    mem_allowin     <= 1'b1;
    @(negedge clk);
    if (out_valid || bj_valid) begin
      protocol_error("item repeated after its transfer");
    end
  endtask

  initial begin
    logic [5:0] i;
    logic [9:0] base;
    seed = 32'h2956_3235;
    mismatch_count = 0;
    protocol_count = 0;
    for (i = 6'd0; i < 6'd32; i = i + 6'd1) begin
      rf[i[4:0]] = {$random(seed), $random(seed)};
    end
    rf[0] = 64'd0;
    $readmemh("tb/ex_input.txt", vec);

    rst             <= 1'b1;
    in_valid        <= 1'b0;
    in_pc           <= '0;
    in_rs1_addr     <= '0;
    in_rs2_addr     <= '0;
    in_use_rs1      <= 1'b0;
    in_use_rs2      <= 1'b0;
    in_op1          <= '0;
    in_op2          <= '0;
    in_alu_op       <= alu_add;
    in_is_word      <= 1'b0;
    in_bj_op        <= bj_none;
    in_imm          <= '0;
    in_rd_wr_ena    <= 1'b0;
    in_rd_addr      <= '0;
    mem_allowin     <= 1'b1;
    mem_fwd_wr_ena  <= 1'b0;
    mem_fwd_addr    <= '0;
    mem_fwd_data    <= '0;
    mem_fwd_is_load <= 1'b0;
    wb_fwd_wr_ena   <= 1'b0;
    wb_fwd_addr     <= '0;
    wb_fwd_data     <= '0;
    bj_ready        <= 1'b0;

    for (i = 6'd0; i < 6'd16; i = i + 6'd1) begin
      @(posedge clk);
      if (i == 6'd15) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_idle("during reset");
    end
    @(negedge clk);
    check_idle("right after reset");

    base = 10'd0;
    for (int op = 0; op < n_ops; op++) begin
      run_op(op, base);
      base = base + 10'd26;
    end
    report_and_finish(1'b0);
  end

endmodule

`default_nettype wire

// ==== tb/ex_input.txt ====
// pc rs1 rs2 use1 use2 op1 op2 alu word bj imm rd | mem: ena addr data load | wb: ena addr data
// load_stall mem_stall bj_stall | sel exp_result exp_taken exp_target (result = rf[sel] + exp)
100 0 0 0 0 7fffffffffffffff 1 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 8000000000000000 0 0
104 0 0 0 0 5 7 1 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0 fffffffffffffffe 0 0
108 0 0 0 0 1 3f 2 0 0 0 3 0 0 0 0 0 0 0 0 4 0 0 8000000000000000 0 0
10c 0 0 0 0 ffffffffffffffff 1 3 0 0 0 4 0 0 0 0 0 0 0 0 0 0 0 1 0 0
110 0 0 0 0 ffffffffffffffff 1 4 0 0 0 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0
114 0 0 0 0 f0f0 ff00 5 0 0 0 6 0 0 0 0 0 0 0 0 0 0 0 ff0 0 0
118 0 0 0 0 8000000000000000 4 6 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 800000000000000 0 0
11c 0 0 0 0 8000000000000000 4 7 0 0 0 8 0 0 0 0 0 0 0 0 0 0 0 f800000000000000 0 0
120 0 0 0 0 f0 f 8 0 0 0 9 0 0 0 0 0 0 0 0 0 0 0 ff 0 0
124 0 0 0 0 f0f0 ff00 9 0 0 0 a 0 0 0 0 0 0 0 0 0 0 0 f000 0 0
128 0 0 0 0 7fffffff 1 0 1 0 0 b 0 0 0 0 0 0 0 0 0 0 0 ffffffff80000000 0 0
12c 0 0 0 0 100000000 1 1 1 0 0 c 0 0 0 0 0 0 0 0 0 0 0 ffffffffffffffff 0 0
130 0 0 0 0 1 3f 2 1 0 0 d 0 0 0 0 0 0 0 0 0 0 0 ffffffff80000000 0 0
134 0 0 0 0 80000000 1 3 1 0 0 e 0 0 0 0 0 0 0 0 0 0 0 1 0 0
138 0 0 0 0 1 80000000 4 1 0 0 f 0 0 0 0 0 0 0 0 0 0 0 1 0 0
13c 0 0 0 0 ffffffff0000ffff 8000ff00 5 1 0 0 10 0 0 0 0 0 0 0 0 0 0 0 ffffffff800000ff 0 0
140 0 0 0 0 ffffffff80000000 4 6 1 0 0 11 0 0 0 0 0 0 0 0 0 0 0 8000000 0 0
144 0 0 0 0 80000000 24 7 1 0 0 12 0 0 0 0 0 0 0 0 2 0 0 fffffffff8000000 0 0
148 0 0 0 0 100000f00 f0 8 1 0 0 13 0 0 0 0 0 0 0 0 0 0 0 ff0 0 0
14c 0 0 0 0 ffffffffffffffff ffffffff80000001 9 1 0 0 14 0 0 0 0 0 0 0 0 0 0 0 ffffffff80000001 0 0
150 5 0 1 0 0 3 0 0 0 0 15 0 0 0 0 0 0 0 0 0 0 5 3 0 0
154 6 0 1 0 0 1 0 0 0 0 16 1 6 1000 0 1 6 2000 0 0 0 0 1001 0 0
158 6 0 1 0 0 1 0 0 0 0 17 1 9 1000 0 1 6 2000 0 0 0 0 2001 0 0
15c 0 0 1 0 0 1 0 0 0 0 18 1 0 1234 0 1 0 55 0 0 0 0 1 0 0
160 7 0 1 0 0 2 0 0 0 0 19 1 7 40 1 0 0 0 3 1 0 0 42 0 0
200 1 2 0 0 200 4 0 0 1 20 1 1 2 a 0 1 1 a 0 0 3 0 204 1 220
300 1 2 0 0 300 4 0 0 3 fffffffffffffff0 1 1 2 1 0 1 1 ffffffffffffffff 0 2 0 0 304 1 2f0
400 1 2 0 0 400 4 0 0 5 8 1 1 2 1 0 1 1 ffffffffffffffff 0 0 0 0 404 0 408
500 1 0 0 0 500 4 0 0 8 20 1 0 0 0 0 1 1 1001 0 0 1 0 504 1 1020
600 0 0 0 0 600 4 0 0 7 100 1 0 0 0 0 0 0 0 0 0 0 0 604 1 700

// ==== filelist.f ====
common/ex_pkg.sv
ex_stage/ex_ctrl.sv
ex_stage/ex_forward.sv
ex_stage/ex_alu.sv
ex_stage/ex_branch.sv
hdl/ex_top.sv
tb/ex_top_sva.sv
tb/ex_top_tb.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_top_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) tb/ex_input.txt
	./$(BIN) | tee $(LOG)
	@grep -q '^Finished with no errors$$' $(LOG) && echo "run passed" || \
		{ echo "run failed"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
